/* Makefile */
TB_TOP := ex_subsystem_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
		--top-module $(TB_TOP) -Mdir obj_dir -f ex_subsystem.f
	@out="$$(./obj_dir/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

/* bench/ex_subsystem_tb.sv */
//----------------------------------------------------------------------
// trace-driven testbench for the execute slice
// random input gaps and commit back-pressure around in-order commit checks
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ex_subsystem_tb;

  localparam int          max_ops   = 64;
  localparam int          n_fields  = 7;   // uop rs1 rs2 rd imm waddr wdata
  localparam int          n_direct  = 4;   // opening ops without gaps or back-pressure
  localparam logic [31:0] lfsr_taps = 32'h8020_0003;
  localparam logic [31:0] lfsr_seed = 32'h294e_a8e4;

  logic                  clk;
  logic                  rst;
  logic                  inst_val;
  logic                  inst_rdy;
  rv_isa_pkg::rv_uop     inst_uop;
  rv_isa_pkg::reg_addr_t inst_rs1;
  rv_isa_pkg::reg_addr_t inst_rs2;
  rv_isa_pkg::reg_addr_t inst_rd;
  rv_isa_pkg::imm_t      inst_imm;
  logic                  commit_val;
  logic                  commit_rdy;
  rv_isa_pkg::reg_addr_t commit_waddr;
  logic [31:0]           commit_wdata;

  logic [31:0] trace_mem [max_ops*n_fields];  // n_fields words per op
  logic [31:0] lfsr_state;
  int          n_ops;
  int          n_commits;
  int          n_errors;
  int          n_checks;
  bit          loaded;     // releases the watchdog

  ex_subsystem #(.p_data_bits(32)) i_dut (
    .clk, .rst,
    .inst_val, .inst_rdy, .inst_uop, .inst_rs1, .inst_rs2, .inst_rd, .inst_imm,
    .commit_val, .commit_rdy, .commit_waddr, .commit_wdata
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // galois lfsr stepped once per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_state[0]};
      if (lfsr_state[0]) lfsr_state = (lfsr_state >> 1) ^ lfsr_taps;
      else               lfsr_state = lfsr_state >> 1;
    end
  endtask

  task automatic print_summary();
    $display("checks: %0d  errors: %0d  commits: %0d of %0d",
             n_checks, n_errors, n_commits, n_ops);
  endtask

  //--------------------------------------------------------------------
  // driver feeds micro-ops in trace order with random idle cycles
  //--------------------------------------------------------------------

  task automatic drive_ops();
    logic [31:0] gap;
    logic        taken;
    int          b;
    for (int i = 0; i < n_ops; i++) begin
      b = i * n_fields;
      if (i >= n_direct) begin
        take_bits(2, gap);  // 0..3 idle cycles
        repeat (gap) begin
          @(posedge clk);
          #2;
        end
      end
      inst_uop = rv_isa_pkg::rv_uop'(trace_mem[b][rv_isa_pkg::uop_w-1:0]);
      inst_rs1 = trace_mem[b+1][4:0];
      inst_rs2 = trace_mem[b+2][4:0];
      inst_rd  = trace_mem[b+3][4:0];
      inst_imm = trace_mem[b+4][11:0];
      inst_val = 1'b1;
      do begin
        @(negedge clk);
        taken = inst_rdy;  // settled mid-cycle for the transfer at the next edge
        @(posedge clk);
        #2;
      end while (!taken);
      inst_val = 1'b0;
    end
  endtask

  //--------------------------------------------------------------------
  // monitor checks commits and drives back-pressure
  //--------------------------------------------------------------------

  task automatic watch_commits();
    logic [31:0] r;
    logic        next_rdy;
    int          b;
    while (n_commits < n_ops) begin
      @(negedge clk);
      if (commit_val && commit_rdy) begin
        b = n_commits * n_fields;
        n_checks++;
        if (commit_waddr !== trace_mem[b+5][4:0]) begin
          $display("Error: t=%0t commit_waddr (op %0d) expected %h got %h",
                   $time, n_commits, trace_mem[b+5][4:0], commit_waddr);
          n_errors++;
        end
        if (commit_wdata !== trace_mem[b+6]) begin
          $display("Error: t=%0t commit_wdata (op %0d) expected %h got %h",
                   $time, n_commits, trace_mem[b+6], commit_wdata);
          n_errors++;
        end
        n_commits++;
      end
      next_rdy = 1'b1;
      if (n_commits >= n_direct) begin
        take_bits(2, r);
        next_rdy = (r != 0);  // low one cycle in four
      end
      @(posedge clk);
      #2;
      commit_rdy = next_rdy;
    end
    commit_rdy = 1'b1;
  endtask

  // first op's commit_val rises on the second edge counting the transfer edge
  task automatic check_first_latency();
    do begin
      @(negedge clk);
    end while (!(inst_val && inst_rdy));
    @(posedge clk);  // inst transfer
    @(negedge clk);
    n_checks++;
    if (commit_val !== 1'b0) begin
      $display("Error: t=%0t commit_val expected 0 got %b", $time, commit_val);
      n_errors++;
    end
    @(negedge clk);
    n_checks++;
    if (commit_val !== 1'b1) begin
      $display("Error: t=%0t commit_val expected 1 got %b", $time, commit_val);
      n_errors++;
    end
  endtask

  //--------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------

  initial begin
    rst        = 1'b1;
    inst_val   = 1'b0;
    inst_uop   = rv_isa_pkg::OP_ADD;
    inst_rs1   = '0;
    inst_rs2   = '0;
    inst_rd    = '0;
    inst_imm   = '0;
    commit_rdy = 1'b1;
    lfsr_state = lfsr_seed;
    n_ops      = 0;
    n_commits  = 0;
    n_errors   = 0;
    n_checks   = 0;
    // uop column above 15 marks unused entries
    for (int k = 0; k < max_ops * n_fields; k++) begin
      trace_mem[k] = 32'hee00_0000 | 32'(k);
    end
    $readmemh("bench/ex_trace.txt", trace_mem);
    while (n_ops < max_ops && trace_mem[n_ops*n_fields] < 16) n_ops++;
    loaded = 1'b1;
    if (n_ops == 0) begin
      $display("Error: trace file holds no micro-ops");
      n_errors++;
    end
    repeat (2) @(posedge clk);
    #2 rst = 1'b0;
    @(negedge clk);
    n_checks++;
    if (commit_val !== 1'b0) begin
      $display("Error: t=%0t commit_val expected 0 got %b", $time, commit_val);
      n_errors++;
    end
    if (inst_rdy !== 1'b1) begin
      $display("Error: t=%0t inst_rdy expected 1 got %b", $time, inst_rdy);
      n_errors++;
    end
    @(posedge clk);
    #2;
    if (n_ops > 0) begin
      fork
        drive_ops();
        watch_commits();
        check_first_latency();
      join
    end
    repeat (4) begin  // nothing may commit twice
      @(negedge clk);
      n_checks++;
      if (commit_val !== 1'b0) begin
        $display("Error: a commit was offered after all %0d micro-ops committed", n_ops);
        n_errors++;
      end
    end
    print_summary();
    if (n_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // watchdog scaled to trace length
  initial begin
    wait (loaded);
    repeat (n_ops * 20 + 100) @(posedge clk);
    $display("Error: timeout, only %0d of %0d micro-ops committed", n_commits, n_ops);
    n_errors++;
    print_summary();
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/ex_trace.txt */
// columns (hex): uop rs1 rs2 rd imm | expected commit_waddr commit_wdata
// uop: 0 add 1 sub 2 and 3 or 4 xor 5 slt 6 sltu 7 sll 8 srl 9 sra a addi b andi c ori d xori
a 00 00 01 7ff 01 000007ff
a 00 00 02 800 02 fffff800
a 00 00 03 005 03 00000005
d 00 00 04 fff 04 ffffffff
0 01 02 05 000 05 ffffffff
1 05 03 06 000 06 fffffffa
5 06 03 07 000 07 00000001
6 06 03 08 000 08 00000000
9 02 03 09 000 09 ffffffc0
8 02 03 0a 000 0a 07ffffc0
7 0a 03 0b 000 0b fffff800
3 01 0b 0c 000 0c ffffffff
2 0c 0a 0d 000 0d 07ffffc0
4 0d 04 0e 000 0e f800003f
b 0e 00 0f 0f0 0f 00000030
c 0f 00 10 800 10 fffff830
a 10 00 00 001 00 fffff831
0 00 03 11 000 11 00000005
6 11 06 12 000 12 00000001
9 10 12 13 000 13 fffffc18

/* ex_subsystem.f */
hw/rv_isa_pkg.sv
hw/d_x_if.sv
hw/x_w_if.sv
hw/reg_file.sv
hw/decode_issue.sv
hw/alu_unit.sv
hw/writeback_stage.sv
hw/ex_subsystem.sv
bench/ex_subsystem_tb.sv

/* hw/alu_unit.sv */
//----------------------------------------------------------------------
// integer execute unit with a one-entry operand register
// result is computed combinationally from the held micro-op
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module alu_unit #(
  parameter int unsigned p_data_bits = 32
) (
  input wire logic clk,
  input wire logic rst,
  d_x_if.x         D,
  x_w_if.x         W
);

  localparam int unsigned shamt_bits = $clog2(p_data_bits);  // 5 for rv32

  //--------------------------------------------------------------------
  // input register
  //--------------------------------------------------------------------

  logic                   val_q;
  rv_isa_pkg::rv_uop      uop_q;
  logic [p_data_bits-1:0] op1_q;
  logic [p_data_bits-1:0] op2_q;
  rv_isa_pkg::reg_addr_t  waddr_q;
  logic                   d_xfer;
  logic                   w_xfer;

  assign d_xfer = D.val && D.rdy;
  assign w_xfer = W.val && W.rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      val_q <= 1'b0;
    end else if (d_xfer) begin
      val_q <= 1'b1;
    end else if (w_xfer) begin
      val_q <= 1'b0;  // drained with nothing behind it
    end
  end

  // operand payload loads on each decode transfer
  always_ff @(posedge clk) begin
    if (d_xfer) begin
      uop_q   <= D.uop;
      op1_q   <= D.op1;
      op2_q   <= D.op2;
      waddr_q <= D.waddr;
    end
  end

  //--------------------------------------------------------------------
  // arithmetic
  //--------------------------------------------------------------------

  logic [shamt_bits-1:0]  shamt;
  logic [p_data_bits-1:0] result;

  assign shamt = op2_q[shamt_bits-1:0];  // low bits only

  always_comb begin
    case (uop_q)
      rv_isa_pkg::OP_ADD:  result = op1_q + op2_q;
      rv_isa_pkg::OP_SUB:  result = op1_q - op2_q;
      rv_isa_pkg::OP_AND:  result = op1_q & op2_q;
      rv_isa_pkg::OP_OR:   result = op1_q | op2_q;
      rv_isa_pkg::OP_XOR:  result = op1_q ^ op2_q;
      rv_isa_pkg::OP_SLT: begin
        result = {{(p_data_bits-1){1'b0}}, $signed(op1_q) < $signed(op2_q)};
      end
      rv_isa_pkg::OP_SLTU: begin
        result = {{(p_data_bits-1){1'b0}}, op1_q < op2_q};
      end
      rv_isa_pkg::OP_SLL:  result = op1_q << shamt;
      rv_isa_pkg::OP_SRL:  result = op1_q >> shamt;
      rv_isa_pkg::OP_SRA:  result = $unsigned($signed(op1_q) >>> shamt);  // sign fill
      default:             result = '0;  // imm forms folded in decode
    endcase
  end

  //--------------------------------------------------------------------
  // outputs
  //--------------------------------------------------------------------

  assign W.val   = val_q;
  assign W.waddr = waddr_q;
  assign W.wdata = result;
  assign D.rdy   = W.rdy || !val_q;  // empty or leaving this cycle

  // a stalled result must not change under writeback
  a_hold_result : assert property (
    @(posedge clk) disable iff (rst)
    (W.val && !W.rdy) |=> ($stable(W.waddr) && $stable(W.wdata)));

endmodule

`default_nettype wire

/* hw/d_x_if.sv */
//----------------------------------------------------------------------
// decode to execute channel, val/rdy handshake
// carries a base micro-op with both operands already selected
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

interface d_x_if #(
  parameter int unsigned p_data_bits = 32
) ();

  logic                    val;    // decode drives
  logic                    rdy;    // alu drives
  rv_isa_pkg::rv_uop       uop;    // base ops only
  logic [p_data_bits-1:0]  op1;
  logic [p_data_bits-1:0]  op2;    // reg or sign-extended imm
  rv_isa_pkg::reg_addr_t   waddr;  // destination

  modport dec (output val, uop, op1, op2, waddr, input rdy);
  modport x   (input val, uop, op1, op2, waddr, output rdy);

endinterface

`default_nettype wire

/* hw/decode_issue.sv */
//----------------------------------------------------------------------
// issue stage that reads operands, folds immediate forms into base ops
// and stalls on pending destinations held in a scoreboard
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module decode_issue #(
  parameter int unsigned p_data_bits = 32
) (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   inst_val,
  output logic                        inst_rdy,
  input  wire rv_isa_pkg::rv_uop      inst_uop,
  input  wire rv_isa_pkg::reg_addr_t  inst_rs1,
  input  wire rv_isa_pkg::reg_addr_t  inst_rs2,
  input  wire rv_isa_pkg::reg_addr_t  inst_rd,
  input  wire rv_isa_pkg::imm_t       inst_imm,
  output rv_isa_pkg::reg_addr_t       rf_rs1,
  output rv_isa_pkg::reg_addr_t       rf_rs2,
  input  wire logic [p_data_bits-1:0] rf_rdata1,
  input  wire logic [p_data_bits-1:0] rf_rdata2,
  input  wire logic                   wb_wen,     // commit strobe
  input  wire rv_isa_pkg::reg_addr_t  wb_waddr,
  d_x_if.dec                          D
);

  localparam int unsigned imm_bits = $bits(rv_isa_pkg::imm_t);

  logic [31:0]            sb_q;       // one pending bit per register
  logic [31:0]            sb_next;
  logic                   is_imm;
  logic                   hazard;
  logic                   issue;
  rv_isa_pkg::rv_uop      base_uop;
  logic [p_data_bits-1:0] imm_sext;

  //--------------------------------------------------------------------
  // operand select and uop folding
  //--------------------------------------------------------------------

  always_comb begin
    is_imm   = 1'b1;
    base_uop = inst_uop;
    case (inst_uop)
      rv_isa_pkg::OP_ADDI: base_uop = rv_isa_pkg::OP_ADD;
      rv_isa_pkg::OP_ANDI: base_uop = rv_isa_pkg::OP_AND;
      rv_isa_pkg::OP_ORI:  base_uop = rv_isa_pkg::OP_OR;
      rv_isa_pkg::OP_XORI: base_uop = rv_isa_pkg::OP_XOR;
      default:             is_imm   = 1'b0;  // reg-reg op passes as is
    endcase
  end

  assign imm_sext = {{(p_data_bits - imm_bits){inst_imm[imm_bits-1]}}, inst_imm};

  assign rf_rs1 = inst_rs1;
  assign rf_rs2 = inst_rs2;

  // rs2 only matters for reg-reg forms
  assign hazard = (sb_q[inst_rs1] && inst_rs1 != '0) ||
                  (!is_imm && sb_q[inst_rs2] && inst_rs2 != '0);

  assign D.val   = inst_val && !hazard;
  assign D.uop   = base_uop;
  assign D.op1   = rf_rdata1;
  assign D.op2   = is_imm ? imm_sext : rf_rdata2;
  assign D.waddr = inst_rd;
  assign inst_rdy = D.rdy && !hazard;

  assign issue = D.val && D.rdy;

  //--------------------------------------------------------------------
  // scoreboard
  //--------------------------------------------------------------------

  always_comb begin
    sb_next = sb_q;
    if (wb_wen) sb_next[wb_waddr] = 1'b0;                // result landed
    if (issue && inst_rd != '0) sb_next[inst_rd] = 1'b1; // new owner wins
  end

  always_ff @(posedge clk) begin
    if (rst) sb_q <= '0;
    else     sb_q <= sb_next;
  end

  // an offered op stays offered until execute takes it
  a_offer_held : assert property (
    @(posedge clk) disable iff (rst) (D.val && !D.rdy) |=> D.val);

endmodule

`default_nettype wire

/* hw/ex_subsystem.sv */
//----------------------------------------------------------------------
// execute slice top: issue -> alu -> writeback with shared reg file
// micro-ops in on inst_*, results out on commit_*
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ex_subsystem #(
  parameter int unsigned p_data_bits = 32
) (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   inst_val,
  output logic                        inst_rdy,
  input  wire rv_isa_pkg::rv_uop      inst_uop,
  input  wire rv_isa_pkg::reg_addr_t  inst_rs1,
  input  wire rv_isa_pkg::reg_addr_t  inst_rs2,
  input  wire rv_isa_pkg::reg_addr_t  inst_rd,
  input  wire rv_isa_pkg::imm_t       inst_imm,
  output logic                        commit_val,
  input  wire logic                   commit_rdy,
  output rv_isa_pkg::reg_addr_t       commit_waddr,
  output logic [p_data_bits-1:0]      commit_wdata
);

  rv_isa_pkg::reg_addr_t  rf_rs1;
  rv_isa_pkg::reg_addr_t  rf_rs2;
  logic [p_data_bits-1:0] rf_rdata1;
  logic [p_data_bits-1:0] rf_rdata2;
  logic                   rf_wen;    // commit strobe, also clears scoreboard
  rv_isa_pkg::reg_addr_t  rf_waddr;
  logic [p_data_bits-1:0] rf_wdata;

  d_x_if #(.p_data_bits(p_data_bits)) d_x ();
  x_w_if #(.p_data_bits(p_data_bits)) x_w ();

  reg_file #(.p_data_bits(p_data_bits)) i_reg_file (
    .clk, .rst,
    .rs1(rf_rs1), .rs2(rf_rs2), .rdata1(rf_rdata1), .rdata2(rf_rdata2),
    .wen(rf_wen), .waddr(rf_waddr), .wdata(rf_wdata)
  );

  decode_issue #(.p_data_bits(p_data_bits)) i_decode_issue (
    .clk, .rst,
    .inst_val, .inst_rdy, .inst_uop, .inst_rs1, .inst_rs2, .inst_rd, .inst_imm,
    .rf_rs1, .rf_rs2, .rf_rdata1, .rf_rdata2,
    .wb_wen(rf_wen), .wb_waddr(rf_waddr),
    .D(d_x.dec)
  );

  alu_unit #(.p_data_bits(p_data_bits)) i_alu_unit (
    .clk, .rst, .D(d_x.x), .W(x_w.x)
  );

  writeback_stage #(.p_data_bits(p_data_bits)) i_writeback_stage (
    .clk, .rst, .W(x_w.w),
    .commit_val, .commit_rdy, .commit_waddr, .commit_wdata,
    .rf_wen, .rf_waddr, .rf_wdata
  );

endmodule

`default_nettype wire

/* hw/reg_file.sv */
//----------------------------------------------------------------------
// 32-entry integer register file, two async reads, one sync write
// x0 is hardwired to zero on the read side
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module reg_file #(
  parameter int unsigned p_data_bits = 32
) (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire rv_isa_pkg::reg_addr_t  rs1,
  input  wire rv_isa_pkg::reg_addr_t  rs2,
  output logic [p_data_bits-1:0]      rdata1,
  output logic [p_data_bits-1:0]      rdata2,
  input  wire logic                   wen,
  input  wire rv_isa_pkg::reg_addr_t  waddr,
  input  wire logic [p_data_bits-1:0] wdata
);

  logic [p_data_bits-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;  // all entries zero
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;  // x0 writes dropped
    end
  end

  // reads see the old value in a write cycle
  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* hw/rv_isa_pkg.sv */
//----------------------------------------------------------------------
// shared types of the integer execute slice: micro-op encoding,
// register index and raw immediate; referenced by scoped names only
//----------------------------------------------------------------------

`default_nettype none

package rv_isa_pkg;

  localparam int uop_w = 4;  // encoded width of rv_uop, trace fields too

  // micro-ops as they arrive pre-decoded
  // immediate forms are folded into base ops inside decode
  typedef enum logic [uop_w-1:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLT  = 4'd5,   // signed compare
    OP_SLTU = 4'd6,   // unsigned compare
    OP_SLL  = 4'd7,
    OP_SRL  = 4'd8,
    OP_SRA  = 4'd9,   // arithmetic right shift
    OP_ADDI = 4'd10,
    OP_ANDI = 4'd11,
    OP_ORI  = 4'd12,
    OP_XORI = 4'd13
  } rv_uop;

  typedef logic [4:0]  reg_addr_t;  // x0..x31
  typedef logic [11:0] imm_t;       // raw imm, sign-extended in decode

endpackage

`default_nettype wire

/* hw/writeback_stage.sv */
//----------------------------------------------------------------------
// writeback: holds one result, offers it on the commit port and
// writes the register file when the commit is taken
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module writeback_stage #(
  parameter int unsigned p_data_bits = 32
) (
  input  wire logic              clk,
  input  wire logic              rst,
  x_w_if.w                       W,
  output logic                   commit_val,
  input  wire logic              commit_rdy,
  output rv_isa_pkg::reg_addr_t  commit_waddr,
  output logic [p_data_bits-1:0] commit_wdata,
  output logic                   rf_wen,
  output rv_isa_pkg::reg_addr_t  rf_waddr,
  output logic [p_data_bits-1:0] rf_wdata
);

  logic                   val_q;
  rv_isa_pkg::reg_addr_t  waddr_q;
  logic [p_data_bits-1:0] wdata_q;
  logic                   w_xfer;
  logic                   c_xfer;

  assign w_xfer = W.val && W.rdy;
  assign c_xfer = commit_val && commit_rdy;

  always_ff @(posedge clk) begin
    if (rst)         val_q <= 1'b0;
    else if (w_xfer) val_q <= 1'b1;
    else if (c_xfer) val_q <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (w_xfer) begin
      waddr_q <= W.waddr;
      wdata_q <= W.wdata;
    end
  end

  assign W.rdy        = !val_q || commit_rdy;
  assign commit_val   = val_q;
  assign commit_waddr = waddr_q;
  assign commit_wdata = wdata_q;

  // rf write and scoreboard clear on the commit edge
  assign rf_wen   = c_xfer;
  assign rf_waddr = waddr_q;
  assign rf_wdata = wdata_q;

  // an offered commit is only withdrawn by being taken
  a_commit_held : assert property (
    @(posedge clk) disable iff (rst)
    (commit_val && !commit_rdy) |=> commit_val);

endmodule

`default_nettype wire

/* hw/x_w_if.sv */
//----------------------------------------------------------------------
// execute to writeback channel, one result per transfer
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

interface x_w_if #(
  parameter int unsigned p_data_bits = 32
) ();

  logic                    val;    // alu drives
  logic                    rdy;    // writeback drives
  rv_isa_pkg::reg_addr_t   waddr;
  logic [p_data_bits-1:0]  wdata;

  modport x (output val, waddr, wdata, input rdy);
  modport w (input val, waddr, wdata, output rdy);

endinterface

`default_nettype wire
